//--- include/tag_trk_params.svh
`ifndef TAG_TRK_PARAMS_SVH
`define TAG_TRK_PARAMS_SVH

////////////////////
// Tag and CAM sizing
`define TAG_W       4   // ID tag carried by each read
`define TAG_DEPTH   8   // Outstanding reads the CAM can hold

////////////////////
// Payload widths
`define ADDR_W      32  // Request address
`define DATA_W      32  // Response data

////////////////////
// Bookkeeping widths
`define SEQ_W       8   // Issue sequence number, wraps
`define CNT_W       16  // Statistics counters, saturate

`endif

//--- rtl/tag_trk_pkg.sv
`default_nettype none

`include "tag_trk_params.svh"

package tag_trk_pkg;

    // Plain vectors for the widths that mean something
    typedef logic [`TAG_W-1:0]             tag_t;
    typedef logic [`ADDR_W-1:0]            addr_t;
    typedef logic [`DATA_W-1:0]            data_t;
    typedef logic [`SEQ_W-1:0]             seq_t;
    typedef logic [`CNT_W-1:0]             cnt_t;
    typedef logic [$clog2(`TAG_DEPTH)-1:0] slot_t;  // CAM entry index

    typedef struct packed {
        tag_t  tag;
        addr_t addr;
    } req_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } rsp_t;

    typedef struct packed {
        req_t req;
        seq_t seq;      // Stamped at acceptance
    } issue_t;

    // Every cause that applies is set, not only the first
    typedef struct packed {
        tag_t tag;
        logic drain;    // Tracker not in run state
        logic collide;  // Response in the same cycle
        logic dup;      // Tag already outstanding
        logic full;     // No free CAM slot
    } reject_t;

    typedef struct packed {
        cnt_t acc_cnt;
        cnt_t rej_cnt;
        cnt_t orph_cnt;
    } stats_t;

    typedef enum logic [1:0] {
        ST_RUN   = 2'd0,
        ST_DRAIN = 2'd1,
        ST_DONE  = 2'd2
    } drain_state_e;

endpackage : tag_trk_pkg

`default_nettype wire

//--- rtl/cam_tag.sv
`timescale 1ns/100ps
`default_nettype none

`include "tag_trk_params.svh"

module cam_tag #(
    parameter int TAG_W = `TAG_W,      // Tag width
    parameter int DEPTH = `TAG_DEPTH   // Number of entries
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    // Lookup port, request side
    input  wire  [TAG_W-1:0] i_lookup_tag,
    output logic             o_lookup_hit,
    // Allocate a slot
    input  wire              i_mark_valid,
    input  wire  [TAG_W-1:0] i_valid_tag,
    // Release a slot, response side
    input  wire              i_mark_invalid,
    input  wire  [TAG_W-1:0] i_invalid_tag,
    output logic             o_release_hit,
    // Occupancy flags
    output logic             o_tags_empty,
    output logic             o_tags_full
);

    localparam int SLOT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [TAG_W-1:0]  r_tags [DEPTH];  // Stored tags, meaningful only where valid
    logic [DEPTH-1:0]  r_valid;         // One bit per slot
    logic [SLOT_W-1:0] free_idx;        // Lowest empty slot
    logic [DEPTH-1:0]  lookup_match;
    logic [DEPTH-1:0]  release_match;

    ////////////////////
    // Free slot search

    // Walk down so the lowest empty slot is the last one written
    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!r_valid[i]) begin
                free_idx = SLOT_W'(i);
            end
        end
    end

    ////////////////////
    // Match vectors

    // Both compares only look at valid slots, at most one bit set each
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            lookup_match[i]  = r_valid[i] && (r_tags[i] == i_lookup_tag);
            release_match[i] = r_valid[i] && (r_tags[i] == i_invalid_tag);
        end
    end

    assign o_lookup_hit  = |lookup_match;
    assign o_release_hit = |release_match;
    assign o_tags_empty  = ~|r_valid;     // Nothing in flight
    assign o_tags_full   =  &r_valid;     // Every slot taken

    ////////////////////
    // Slot state

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_valid <= '0;
        end else if (i_mark_valid) begin
            r_valid[free_idx] <= 1'b1;               // Claim lowest free slot
        end else if (i_mark_invalid) begin
            r_valid <= r_valid & ~release_match;     // Drop the matching slot
        end
    end

    // Tag storage, written with the slot it lands in
    always_ff @(posedge i_clk) begin
        if (i_mark_valid) begin
            r_tags[free_idx] <= i_valid_tag;
        end
    end

    ////////////////////
    // Checks on the control side

    // Control resolves the collision before it reaches the CAM
    a_no_dual_mark : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_mark_valid && i_mark_invalid))
        else $error("cam_tag: valid and invalid marked in the same cycle");

    // Full guard lives in control, a write here would clobber slot 0
    a_no_mark_full : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mark_valid |-> !o_tags_full)
        else $error("cam_tag: mark_valid while full");

    // Orphans must be filtered out before release
    a_release_hits : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mark_invalid |-> o_release_hit)
        else $error("cam_tag: mark_invalid without a matching tag");

endmodule : cam_tag

`default_nettype wire

//--- rtl/trk_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module trk_ctrl (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    // Requester and memory side strobes
    input  wire                        i_req_vld,
    input  wire  tag_trk_pkg::req_t    i_req,
    input  wire                        i_rsp_vld,
    input  wire  tag_trk_pkg::rsp_t    i_rsp,
    input  wire                        i_drain,     // Level
    // CAM status, combinational
    input  wire                        i_lookup_hit,
    input  wire                        i_release_hit,
    input  wire                        i_tags_empty,
    input  wire                        i_tags_full,
    // CAM commands
    output tag_trk_pkg::tag_t          o_lookup_tag,
    output logic                       o_mark_valid,
    output tag_trk_pkg::tag_t          o_valid_tag,
    output logic                       o_mark_invalid,
    output tag_trk_pkg::tag_t          o_invalid_tag,
    // Decision strobes
    output logic                       o_accept,
    output logic                       o_reject,
    output tag_trk_pkg::reject_t       o_rej_info,
    output logic                       o_retire,
    output logic                       o_orphan,
    output tag_trk_pkg::drain_state_e  o_drain_state
);

    import tag_trk_pkg::*;

    drain_state_e state;
    drain_state_e state_nxt;
    logic         any_cause;    // At least one reject cause present

    ////////////////////
    // Request decision

    assign o_lookup_tag = i_req.tag;                // Dup check on the incoming tag

    always_comb begin
        o_rej_info         = '0;
        o_rej_info.tag     = i_req.tag;
        o_rej_info.drain   = (state != ST_RUN);     // Drain or done blocks new work
        o_rej_info.collide = i_rsp_vld;             // Response owns this cycle
        o_rej_info.dup     = i_lookup_hit;          // Ordering hazard
        o_rej_info.full    = i_tags_full;
    end

    assign any_cause = o_rej_info.drain | o_rej_info.collide
                     | o_rej_info.dup   | o_rej_info.full;

    assign o_accept = i_req_vld && !any_cause;
    assign o_reject = i_req_vld &&  any_cause;

    assign o_mark_valid = o_accept;                 // Never with a response, collide blocks it
    assign o_valid_tag  = i_req.tag;

    ////////////////////
    // Response decision

    assign o_retire       = i_rsp_vld &&  i_release_hit;
    assign o_orphan       = i_rsp_vld && !i_release_hit;   // Unknown tag
    assign o_mark_invalid = o_retire;
    assign o_invalid_tag  = i_rsp.tag;

    ////////////////////
    // Drain FSM

    always_comb begin
        state_nxt = state;
        case (state)
            ST_RUN: begin
                if (i_drain) begin
                    state_nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (!i_drain) begin
                    state_nxt = ST_RUN;             // Drain abandoned
                end else if (i_tags_empty) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                if (!i_drain) begin
                    state_nxt = ST_RUN;
                end
            end
            default: state_nxt = ST_RUN;            // Recover from a bad encoding
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_drain_state = state;

    ////////////////////
    // Checks

    a_state_legal : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state inside {ST_RUN, ST_DRAIN, ST_DONE})
        else $error("trk_ctrl: illegal drain state %0d", state);

    a_acc_rej_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_accept && o_reject))
        else $error("trk_ctrl: accept and reject in the same cycle");

endmodule : trk_ctrl

`default_nettype wire

//--- rtl/trk_out_stage.sv
`timescale 1ns/100ps
`default_nettype none

module trk_out_stage (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    // Decisions from control
    input  wire                        i_accept,
    input  wire  tag_trk_pkg::req_t    i_req,
    input  wire                        i_reject,
    input  wire  tag_trk_pkg::reject_t i_rej_info,
    input  wire                        i_retire,
    input  wire                        i_orphan,
    input  wire  tag_trk_pkg::rsp_t    i_rsp,
    input  wire  tag_trk_pkg::drain_state_e i_drain_state,
    // Registered outputs
    output logic                       o_iss_vld,
    output tag_trk_pkg::issue_t        o_iss,
    output logic                       o_rej_vld,
    output tag_trk_pkg::reject_t       o_rej,
    output logic                       o_rsp_vld,
    output tag_trk_pkg::rsp_t          o_rsp,
    output logic                       o_orphan_vld,
    output tag_trk_pkg::tag_t          o_orphan,
    output logic                       o_drained
);

    import tag_trk_pkg::*;

    seq_t seq_cnt;  // Next sequence number to hand out

    ////////////////////
    // Strobes and sequence counter

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_iss_vld    <= 1'b0;
            o_rej_vld    <= 1'b0;
            o_rsp_vld    <= 1'b0;
            o_orphan_vld <= 1'b0;
            o_drained    <= 1'b0;
            seq_cnt      <= '0;
        end else begin
            o_iss_vld    <= i_accept;
            o_rej_vld    <= i_reject;
            o_rsp_vld    <= i_retire;
            o_orphan_vld <= i_orphan;
            o_drained    <= (i_drain_state == ST_DONE);
            if (i_accept) begin
                seq_cnt <= seq_cnt + seq_t'(1);         // Wraps
            end
        end
    end

    ////////////////////
    // Payloads, held until the next event of their kind

    always_ff @(posedge i_clk) begin
        if (i_accept) begin
            o_iss.req <= i_req;
            o_iss.seq <= seq_cnt;                       // Stamp before the bump
        end
        if (i_reject) begin
            o_rej <= i_rej_info;
        end
        if (i_retire) begin
            o_rsp <= i_rsp;
        end
        if (i_orphan) begin
            o_orphan <= i_rsp.tag;
        end
    end

endmodule : trk_out_stage

`default_nettype wire

//--- rtl/trk_stats.sv
`timescale 1ns/100ps
`default_nettype none

module trk_stats (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire                  i_accept,   // One count per strobe
    input  wire                  i_reject,
    input  wire                  i_orphan,
    output tag_trk_pkg::stats_t  o_stats
);

    import tag_trk_pkg::*;

    // Add one unless already pinned at all ones
    function automatic cnt_t sat_inc(input cnt_t cnt, input logic inc);
        logic at_max;
        at_max = &cnt;
        if (inc && !at_max) begin
            return cnt + cnt_t'(1);
        end
        return cnt;
    endfunction

    ////////////////////
    // Counters

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_stats <= '0;
        end else begin
            o_stats.acc_cnt  <= sat_inc(o_stats.acc_cnt,  i_accept);
            o_stats.rej_cnt  <= sat_inc(o_stats.rej_cnt,  i_reject);
            o_stats.orph_cnt <= sat_inc(o_stats.orph_cnt, i_orphan);
        end
    end

endmodule : trk_stats

`default_nettype wire

//--- rtl/tag_trk_top.sv
`timescale 1ns/100ps
`default_nettype none

module tag_trk_top (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    // Requests, responses, drain
    input  wire                        i_req_vld,
    input  wire  tag_trk_pkg::req_t    i_req,
    input  wire                        i_rsp_vld,
    input  wire  tag_trk_pkg::rsp_t    i_rsp,
    input  wire                        i_drain,
    // Results, one cycle after the strobes
    output logic                       o_iss_vld,
    output tag_trk_pkg::issue_t        o_iss,
    output logic                       o_rej_vld,
    output tag_trk_pkg::reject_t       o_rej,
    output logic                       o_rsp_vld,
    output tag_trk_pkg::rsp_t          o_rsp,
    output logic                       o_orphan_vld,
    output tag_trk_pkg::tag_t          o_orphan,
    output logic                       o_drained,
    output tag_trk_pkg::stats_t        o_stats
);

    import tag_trk_pkg::*;

    // Control to CAM
    tag_t         lookup_tag;
    logic         mark_valid;
    tag_t         valid_tag;
    logic         mark_invalid;
    tag_t         invalid_tag;
    // CAM to control
    logic         lookup_hit;
    logic         release_hit;
    logic         tags_empty;
    logic         tags_full;
    // Decisions
    logic         accept;
    logic         reject;
    reject_t      rej_info;
    logic         retire;
    logic         orphan;
    drain_state_e drain_state;

    trk_ctrl trk_ctrl_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_req_vld      (i_req_vld),
        .i_req          (i_req),
        .i_rsp_vld      (i_rsp_vld),
        .i_rsp          (i_rsp),
        .i_drain        (i_drain),
        .i_lookup_hit   (lookup_hit),
        .i_release_hit  (release_hit),
        .i_tags_empty   (tags_empty),
        .i_tags_full    (tags_full),
        .o_lookup_tag   (lookup_tag),
        .o_mark_valid   (mark_valid),
        .o_valid_tag    (valid_tag),
        .o_mark_invalid (mark_invalid),
        .o_invalid_tag  (invalid_tag),
        .o_accept       (accept),
        .o_reject       (reject),
        .o_rej_info     (rej_info),
        .o_retire       (retire),
        .o_orphan       (orphan),
        .o_drain_state  (drain_state)
    );

    cam_tag cam_tag_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_lookup_tag   (lookup_tag),
        .o_lookup_hit   (lookup_hit),
        .i_mark_valid   (mark_valid),
        .i_valid_tag    (valid_tag),
        .i_mark_invalid (mark_invalid),
        .i_invalid_tag  (invalid_tag),
        .o_release_hit  (release_hit),
        .o_tags_empty   (tags_empty),
        .o_tags_full    (tags_full)
    );

    trk_out_stage trk_out_stage_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_accept       (accept),
        .i_req          (i_req),
        .i_reject       (reject),
        .i_rej_info     (rej_info),
        .i_retire       (retire),
        .i_orphan       (orphan),
        .i_rsp          (i_rsp),
        .i_drain_state  (drain_state),
        .o_iss_vld      (o_iss_vld),
        .o_iss          (o_iss),
        .o_rej_vld      (o_rej_vld),
        .o_rej          (o_rej),
        .o_rsp_vld      (o_rsp_vld),
        .o_rsp          (o_rsp),
        .o_orphan_vld   (o_orphan_vld),
        .o_orphan       (o_orphan),
        .o_drained      (o_drained)
    );

    trk_stats trk_stats_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_accept       (accept),
        .i_reject       (reject),
        .i_orphan       (orphan),
        .o_stats        (o_stats)
    );

endmodule : tag_trk_top

`default_nettype wire

//--- tb/tb_tag_trk.sv
`timescale 1ns/100ps
`default_nettype none

`include "tag_trk_params.svh"

module tb_tag_trk;

    import tag_trk_pkg::*;

    localparam int RAND_CYCLES = 1500;                // Random mix length
    localparam int TIMEOUT     = RAND_CYCLES + 1000;  // Directed tests plus margin

    logic clk;
    logic rst_n;
    logic req_vld;
    req_t req;
    logic rsp_vld;
    rsp_t rsp;
    logic drain;
    logic iss_vld, rej_vld, rsp_out_vld, orphan_vld, drained;
    issue_t  iss;
    reject_t rej;
    rsp_t    rsp_out;
    tag_t    orphan;
    stats_t  stats;

    // Reference model state
    logic         out_set [16];  // Outstanding tags
    int           out_cnt;
    seq_t         m_seq;
    drain_state_e m_st;
    stats_t       m_stats;
    // Expected outputs for the next cycle
    logic    exp_iss_vld, exp_rej_vld, exp_rsp_vld, exp_orph_vld, exp_drained;
    issue_t  exp_iss;
    reject_t exp_rej;
    rsp_t    exp_rsp;
    tag_t    exp_orph;

    logic [15:0] lfsr;
    logic        drain_lvl;      // Level applied on every step
    int          n_checks, n_err, err_mark, cyc;

    tag_trk_top tag_trk_top_inst (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_req_vld(req_vld), .i_req(req), .i_rsp_vld(rsp_vld), .i_rsp(rsp), .i_drain(drain),
        .o_iss_vld(iss_vld), .o_iss(iss), .o_rej_vld(rej_vld), .o_rej(rej),
        .o_rsp_vld(rsp_out_vld), .o_rsp(rsp_out), .o_orphan_vld(orphan_vld),
        .o_orphan(orphan), .o_drained(drained), .o_stats(stats)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cyc++;
        if (cyc >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////
    // Random numbers

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic req_t mk_req(input tag_t t);
        req_t r;
        r.tag  = t;
        r.addr = addr_t'(rand_bits(`ADDR_W));
        return r;
    endfunction

    function automatic rsp_t mk_rsp(input tag_t t);
        rsp_t r;
        r.tag  = t;
        r.data = data_t'(rand_bits(`DATA_W));
        return r;
    endfunction

    // Mostly an outstanding tag and now and then any tag
    function automatic tag_t pick_rsp_tag();
        tag_t q [$];
        for (int i = 0; i < 16; i++) begin
            if (out_set[i]) q.push_back(tag_t'(i));
        end
        if (q.size() == 0 || rand_bits(2) == 0) return tag_t'(rand_bits(`TAG_W));
        return q[rand_bits(8) % q.size()];
    endfunction

    function automatic cnt_t bump_count(input cnt_t c, input logic inc);
        if (inc && c != {`CNT_W{1'b1}}) return c + cnt_t'(1);  // Pins at max
        return c;
    endfunction

    ////////////////////
    // Compare tasks

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t %s got %0b exp %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_iss(input issue_t got, input issue_t exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t o_iss got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_rej(input reject_t got, input reject_t exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t o_rej got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_rsp(input rsp_t got, input rsp_t exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t o_rsp got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t o_orphan got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_stats(input stats_t got, input stats_t exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("MISMATCH t=%0t o_stats got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_bit("o_iss_vld", iss_vld, exp_iss_vld);
        check_bit("o_rej_vld", rej_vld, exp_rej_vld);
        check_bit("o_rsp_vld", rsp_out_vld, exp_rsp_vld);
        check_bit("o_orphan_vld", orphan_vld, exp_orph_vld);
        check_bit("o_drained", drained, exp_drained);
        if (exp_iss_vld) check_iss(iss, exp_iss);       // Payloads only with their strobe
        if (exp_rej_vld) check_rej(rej, exp_rej);
        if (exp_rsp_vld) check_rsp(rsp_out, exp_rsp);
        if (exp_orph_vld) check_tag(orphan, exp_orph);
        check_stats(stats, m_stats);
    endtask

    ////////////////////
    // Reference model called once per cycle of inputs

    task automatic model_cycle(input logic rv, input req_t rq, input logic sv, input rsp_t rs,
                               input logic dr);
        logic drn, coll, dup, full, acc, hit, empty;
        drn   = (m_st != ST_RUN);
        coll  = sv;                                 // Response wins the cycle
        dup   = out_set[rq.tag];
        full  = (out_cnt == `TAG_DEPTH);
        acc   = rv && !(drn || coll || dup || full);
        hit   = sv && out_set[rs.tag];
        empty = (out_cnt == 0);                     // Occupancy before this cycle's update
        exp_iss_vld     = acc;
        exp_iss.req     = rq;
        exp_iss.seq     = m_seq;
        exp_rej_vld     = rv && !acc;
        exp_rej.tag     = rq.tag;
        exp_rej.drain   = drn;
        exp_rej.collide = coll;
        exp_rej.dup     = dup;
        exp_rej.full    = full;
        exp_rsp_vld     = hit;
        exp_rsp         = rs;
        exp_orph_vld    = sv && !hit;
        exp_orph        = rs.tag;
        exp_drained     = (m_st == ST_DONE);
        if (acc) begin
            m_seq++;                                // Wraps at SEQ_W
            out_set[rq.tag] = 1'b1;
            out_cnt++;
        end
        if (hit) begin
            out_set[rs.tag] = 1'b0;
            out_cnt--;
        end
        m_stats.acc_cnt  = bump_count(m_stats.acc_cnt, acc);
        m_stats.rej_cnt  = bump_count(m_stats.rej_cnt, rv && !acc);
        m_stats.orph_cnt = bump_count(m_stats.orph_cnt, sv && !hit);
        case (m_st)
            ST_RUN: begin
                if (dr) m_st = ST_DRAIN;
            end
            ST_DRAIN: begin
                if (!dr) begin
                    m_st = ST_RUN;
                end else if (empty) begin
                    m_st = ST_DONE;
                end
            end
            default: begin                          // ST_DONE
                if (!dr) m_st = ST_RUN;
            end
        endcase
    endtask

    // Check last cycle's results and then drive the next inputs
    task automatic step(input logic rv, input req_t rq, input logic sv, input rsp_t rs);
        @(posedge clk);
        #2;
        check_outputs();
        req_vld = rv;
        req     = rq;
        rsp_vld = sv;
        rsp     = rs;
        drain   = drain_lvl;
        model_cycle(rv, rq, sv, rs, drain_lvl);
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, '0);
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %s, %0d errors", name, (n_err == err_mark) ? "ok" : "failed",
                 n_err - err_mark);
        err_mark = n_err;
    endtask

    ////////////////////
    // Tests

    initial begin
        int waited;
        clk       = 0;
        rst_n     = 0;
        req_vld   = 0;
        req       = '0;
        rsp_vld   = 0;
        rsp       = '0;
        drain     = 0;
        lfsr      = 16'd26;
        drain_lvl = 0;
        n_checks  = 0;
        n_err     = 0;
        err_mark  = 0;
        cyc       = 0;
        for (int i = 0; i < 16; i++) out_set[i] = 1'b0;
        out_cnt = 0;
        m_seq   = '0;
        m_st    = ST_RUN;
        m_stats = '0;
        {exp_iss_vld, exp_rej_vld, exp_rsp_vld, exp_orph_vld, exp_drained} = '0;
        repeat (4) @(posedge clk);                      // Reset for 4 cycles
        #2 rst_n = 1;

        // Fill the CAM and overflow it
        for (int t = 0; t < 11; t++) step(1'b1, mk_req(tag_t'(t)), 1'b0, '0);
        idle();
        end_test("fill");

        // Dup while full then retire and reuse the tag
        step(1'b1, mk_req(4'd3), 1'b0, '0);
        step(1'b0, '0, 1'b1, mk_rsp(4'd3));
        step(1'b1, mk_req(4'd3), 1'b0, '0);
        idle();
        end_test("dup");

        // Retire everything with a few orphans in between
        for (int t = 0; t < 8; t++) begin
            step(1'b0, '0, 1'b1, mk_rsp(tag_t'(t)));
            if (t % 3 == 0) step(1'b0, '0, 1'b1, mk_rsp(tag_t'(9 + t)));  // Unknown tags
        end
        idle();
        end_test("response");

        // Request against retire and against orphan
        step(1'b1, mk_req(4'd1), 1'b0, '0);
        step(1'b1, mk_req(4'd2), 1'b1, mk_rsp(4'd1));
        step(1'b1, mk_req(4'd6), 1'b1, mk_rsp(4'd11));
        step(1'b1, mk_req(4'd2), 1'b0, '0);
        idle();
        end_test("collide");

        // Drain with tags 2 4 5 in flight
        step(1'b1, mk_req(4'd4), 1'b0, '0);
        drain_lvl = 1;
        step(1'b1, mk_req(4'd5), 1'b0, '0);             // Still in run this cycle
        idle();
        step(1'b1, mk_req(4'd7), 1'b0, '0);             // Blocked by drain
        step(1'b0, '0, 1'b1, mk_rsp(4'd2));
        step(1'b0, '0, 1'b1, mk_rsp(4'd4));
        step(1'b0, '0, 1'b1, mk_rsp(4'd5));
        waited = 0;
        while (!drained && waited < 10) begin
            idle();
            waited++;
        end
        if (!drained) begin
            n_err++;
            $display("ERROR t=%0t: o_drained did not rise once the tags were retired", $time);
        end
        drain_lvl = 0;
        waited = 0;
        while (drained && waited < 10) begin
            idle();
            waited++;
        end
        if (drained) begin
            n_err++;
            $display("ERROR t=%0t: o_drained stayed high after drain was released", $time);
        end
        step(1'b1, mk_req(4'd8), 1'b0, '0);             // Accepting again
        step(1'b0, '0, 1'b1, mk_rsp(4'd8));
        idle();
        end_test("drain");

        // Random mix with every output checked each cycle
        for (int i = 0; i < RAND_CYCLES; i++) begin
            if (rand_bits(6) == 0) drain_lvl = ~drain_lvl;  // Rare drain toggles
            step(rand_bits(1) != 0, mk_req(tag_t'(rand_bits(`TAG_W))),
                 rand_bits(1) != 0, mk_rsp(pick_rsp_tag()));
        end
        drain_lvl = 0;
        repeat (3) idle();
        end_test("random");

        $display("checks %0d, errors %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_tag_trk

`default_nettype wire

//--- sim.f
+incdir+include
rtl/tag_trk_pkg.sv
rtl/cam_tag.sv
rtl/trk_ctrl.sv
rtl/trk_out_stage.sv
rtl/trk_stats.sv
rtl/tag_trk_top.sv
tb/tb_tag_trk.sv

//--- Bender.yml
package:
  name: tag_trk

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/tag_trk_pkg.sv
      - rtl/cam_tag.sv
      - rtl/trk_ctrl.sv
      - rtl/trk_out_stage.sv
      - rtl/trk_stats.sv
      - rtl/tag_trk_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_tag_trk.sv
